//--- files.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/group_extract.sv
rtl/group_fifo.sv
rtl/flow_scan.sv
rtl/fetch_group_top.sv
dv/tb_clock.sv
dv/tb_fetch_group.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_group \
	-f files.f -Mdir obj_dir &&
./obj_dir/Vtb_fetch_group | tee /dev/stderr | grep "^Result: PASSED$" > /dev/null &&
echo "Simulation finished without errors" ||
{ echo "Simulation reported errors or did not build"; exit 1; }

//--- dv/tb_fetch_group.sv
`timescale 1ns/1ps

module tb_fetch_group;
	import isa_pkg::*;
	import fetch_pkg::*;

	// Fetches issued by the stimulus below, and the watchdog budget built from them
	localparam int N_FETCH = 53;
	localparam int WDOG_NS = 200 * N_FETCH * 10;

	// One expected result, as the outside should see it on grp_valid_o
	typedef struct packed {
		group_t      grp;
		slot_valid_t vld;
		pc_t         pc;
		logic        flow;
		logic        call;
		logic        ret;
		pc_t         tgt;
		pc_t         retpc;
	} exp_t;

	logic        clk;
	logic        rst_i;
	logic        fetch_valid_i;
	pc_t         fetch_pc_i;
	line_t       fetch_line_i;
	logic        hwi_i;
	logic        miss_i;
	pc_t         miss_pc_i;
	logic        fetch_ready_o;
	logic        credit_i = 1'b0;
	logic        grp_valid_o;
	group_t      grp_o;
	slot_valid_t grp_vld_o;
	pc_t         grp_pc_o;
	logic        do_flow_o;
	logic        do_call_o;
	logic        do_ret_o;
	pc_t         tgt_pc_o;
	pc_t         ret_pc_o;

	int     seed = 23;
	int     errors = 0;
	int     delivered = 0;
	int     credits_back = 0;
	int     credits_given = 0;
	int     q_size = 0;
	logic   hold = 1'b0;
	logic   any_accepted = 1'b0;
	logic   seen_valid;
	logic   seen_ready;
	exp_t   model_q [$];
	exp_t   exp_head = '0;
	pc_t    prev_pc;
	group_t prev_al;

	tb_clock u_clock (.clk(clk), .rst_o(rst_i));

	fetch_group_top u_dut (
		.clk(clk), .rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i), .fetch_line_i(fetch_line_i),
		.hwi_i(hwi_i), .miss_i(miss_i), .miss_pc_i(miss_pc_i), .fetch_ready_o(fetch_ready_o),
		.credit_i(credit_i), .grp_valid_o(grp_valid_o), .grp_o(grp_o), .grp_vld_o(grp_vld_o),
		.grp_pc_o(grp_pc_o), .do_flow_o(do_flow_o), .do_call_o(do_call_o), .do_ret_o(do_ret_o),
		.tgt_pc_o(tgt_pc_o), .ret_pc_o(ret_pc_o)
	);

	// ========================================================================
	// Reference model
	// ========================================================================

	// Slot k takes line word (pc word index + k), a NOP once that runs off the line
	function automatic group_t align_line(input pc_t pc, input line_t line);
		int     idx;
		group_t g;
		for (int k = 0; k < SLOTS; k++)
		begin
			idx = int'(pc[4:2]) + k;
			g[k*WORD_BITS +: WORD_BITS] = (idx < LINE_WORDS) ? line[idx*WORD_BITS +: WORD_BITS]
				: NOP_WORD;
		end
		return g;
	endfunction

	function automatic exp_t expect_group(input pc_t pc, input line_t line, input logic hwi,
		input logic miss, input pc_t mpc, input pc_t last_pc, input group_t last_al);
		exp_t   e;
		group_t al;
		word_t  w;
		pc_t    addr;
		pc_t    ofs;
		logic   found;
		al = align_line(pc, line);
		// A repeat of the last accepted PC and aligned words issues as NOPs
		e.grp   = (pc == last_pc && al == last_al) ? {SLOTS{NOP_WORD}} : al;
		e.pc    = pc;
		e.flow  = 1'b0;
		e.call  = 1'b0;
		e.ret   = 1'b0;
		e.tgt   = RST_PC;
		e.retpc = RST_PC;
		found   = 1'b0;
		for (int k = 0; k < SLOTS; k++)
		begin
			addr     = pc + pc_t'(4 * k);
			e.vld[k] = !hwi && !(miss && mpc > addr);
			w        = e.grp[k*WORD_BITS +: WORD_BITS];
			// Signed word displacement turned into a byte offset
			ofs      = pc_t'($signed(w[DISP_LSB +: DISP_BITS])) << 2;
			if (!found && e.vld[k])
			begin
				if ((w[4:0] == OP_BL && w[7:5] != 3'd7) || w[4:0] == OP_JSR)
				begin
					found  = 1'b1;
					e.flow = 1'b1;
					e.call = (w[7:5] != 3'd0);
					e.tgt  = (w[4:0] == OP_BL) ? addr + ofs : ofs;
					if (e.call)
						e.retpc = addr + RET_OFS;
				end
				else if (w[4:0] == OP_RTD && w[9:8] == 2'd0)
				begin
					found = 1'b1;
					e.ret = 1'b1;
				end
			end
		end
		return e;
	endfunction

	// Outputs are sampled on the falling edge, where nothing in the DUT moves
	always @(negedge clk)
	begin
		seen_valid = grp_valid_o;
		seen_ready = fetch_ready_o;
		// Hand back one credit per delivered group unless back-pressure is on
		credit_i   = !rst_i && !hold && (credits_given < delivered);
		if (credit_i)
			credits_given++;
	end

	// Bookkeeping follows the DUT's edges, so the head is settled before each check
	always @(posedge clk)
	begin
		if (rst_i)
		begin
			prev_pc = '0;
			prev_al = '0;
		end
		else
		begin
			if (credit_i)
				credits_back++;
			if (seen_valid)
			begin
				delivered++;
				if (model_q.size() != 0)
					void'(model_q.pop_front());
			end
			if (fetch_valid_i && seen_ready)
			begin
				model_q.push_back(expect_group(fetch_pc_i, fetch_line_i, hwi_i, miss_i,
					miss_pc_i, prev_pc, prev_al));
				prev_pc      = fetch_pc_i;
				prev_al      = align_line(fetch_pc_i, fetch_line_i);
				any_accepted = 1'b1;
			end
			q_size = model_q.size();
			if (q_size != 0)
				exp_head = model_q[0];
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic flag_error(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	a_idle: assert property (@(negedge clk) disable iff (rst_i)
		!any_accepted |-> (fetch_ready_o && !grp_valid_o))
		else flag_error("output activity before the first accepted fetch");

	a_known: assert property (@(negedge clk) disable iff (rst_i)
		grp_valid_o |-> (q_size != 0))
		else flag_error($sformatf("group for pc %h with no fetch outstanding", grp_pc_o));

	a_group: assert property (@(negedge clk) disable iff (rst_i)
		grp_valid_o |-> (grp_o == exp_head.grp && grp_vld_o == exp_head.vld
			&& grp_pc_o == exp_head.pc))
		else flag_error($sformatf("pc %h vld %b slots %h, expected pc %h vld %b slots %h",
			grp_pc_o, grp_vld_o, grp_o, exp_head.pc, exp_head.vld, exp_head.grp));

	a_flags: assert property (@(negedge clk) disable iff (rst_i)
		grp_valid_o |-> ({do_flow_o, do_call_o, do_ret_o}
			== {exp_head.flow, exp_head.call, exp_head.ret}))
		else flag_error($sformatf("pc %h flow/call/ret %b%b%b, expected %b%b%b", grp_pc_o,
			do_flow_o, do_call_o, do_ret_o, exp_head.flow, exp_head.call, exp_head.ret));

	a_targets: assert property (@(negedge clk) disable iff (rst_i)
		grp_valid_o |-> (tgt_pc_o == exp_head.tgt && ret_pc_o == exp_head.retpc))
		else flag_error($sformatf("pc %h tgt %h ret %h, expected tgt %h ret %h", grp_pc_o,
			tgt_pc_o, ret_pc_o, exp_head.tgt, exp_head.retpc));

	// With the queue full of undelivered groups the fetch side must be closed
	a_fifo_full: assert property (@(negedge clk) disable iff (rst_i)
		(q_size >= FIFO_DEPTH) |-> !fetch_ready_o)
		else flag_error($sformatf("fetch_ready_o high with %0d groups undelivered", q_size));

	a_out_credit: assert property (@(negedge clk) disable iff (rst_i)
		(delivered - credits_back) <= OUT_CREDITS)
		else flag_error($sformatf("%0d results out against %0d credits", delivered,
			credits_back + OUT_CREDITS));

	// ========================================================================
	// Stimulus
	// ========================================================================

	function automatic pc_t rand_pc();
		return {$random(seed)} & 32'hFFFF_FFFC;
	endfunction

	// One word of a given flow form, the rest of its bits random
	function automatic word_t form_word(input int form, input word_t r);
		word_t w;
		w = r;
		case (form)
			0: w = NOP_WORD;
			1: w[7:0] = {3'd0, OP_BL};
			2: w[7:0] = {3'd3, OP_BL};
			3: w[7:0] = {3'd7, OP_BL};
			4: w[7:0] = {3'd0, OP_JSR};
			5: w[7:0] = {3'd5, OP_JSR};
			6: w[9:0] = {2'd0, w[7:5], OP_RTD};
			default: w[9:0] = {2'd1, w[7:5], OP_RTD};
		endcase
		return w;
	endfunction

	// Line of fully random words, or of words drawn from the flow forms
	function automatic line_t rand_line(input logic forms);
		line_t l;
		for (int i = 0; i < LINE_WORDS; i++)
			l[i*WORD_BITS +: WORD_BITS] = forms ? form_word({$random(seed)} % 8, $random(seed))
				: word_t'($random(seed));
		return l;
	endfunction

	// Present one fetch on a falling edge once the DUT is ready for it
	task automatic issue_fetch(input pc_t pc, input line_t line, input logic hwi,
		input logic miss, input pc_t mpc);
		while (!fetch_ready_o)
			@(negedge clk);
		fetch_valid_i = 1'b1;
		fetch_pc_i    = pc;
		fetch_line_i  = line;
		hwi_i         = hwi;
		miss_i        = miss;
		miss_pc_i     = mpc;
		@(negedge clk);
		fetch_valid_i = 1'b0;
	endtask

	initial
	begin
		pc_t   pc;
		line_t line;
		logic  hwi;
		logic  miss;
		fetch_valid_i = 1'b0;
		fetch_pc_i    = '0;
		fetch_line_i  = '0;
		hwi_i         = 1'b0;
		miss_i        = 1'b0;
		miss_pc_i     = '0;
		while (rst_i !== 1'b0)
			@(negedge clk);
		// A few idle cycles so the state right after reset is observed
		repeat (4)
			@(negedge clk);
		// Alignment over random lines and PCs
		repeat (16)
			issue_fetch(rand_pc(), rand_line(1'b0), 1'b0, 1'b0, '0);
		// Same PC and line twice in a row
		pc   = rand_pc();
		line = rand_line(1'b0);
		repeat (2)
			issue_fetch(pc, line, 1'b0, 1'b0, '0);
		// Interrupt, then misses that clear two slots, every slot and none
		issue_fetch(rand_pc(), rand_line(1'b0), 1'b1, 1'b0, '0);
		pc = rand_pc();
		issue_fetch(pc, rand_line(1'b0), 1'b0, 1'b1, pc + 32'd8);
		issue_fetch(pc + 32'd64, rand_line(1'b0), 1'b0, 1'b1, pc + 32'd80);
		issue_fetch(pc, rand_line(1'b0), 1'b0, 1'b1, pc);
		// Flow forms in every slot position, some slots killed by a miss or interrupt
		repeat (24)
		begin
			pc   = rand_pc();
			hwi  = ({$random(seed)} % 8) == 0;
			miss = $random(seed) & 1;
			issue_fetch(pc, rand_line(1'b1), hwi, miss, pc + pc_t'(4 * ({$random(seed)} % 6)) - 4);
		end
		issue_fetch(rand_pc(), {LINE_WORDS{NOP_WORD}}, 1'b0, 1'b0, '0);
		// Drain, then fill the queue with output credits held back
		while (q_size != 0 || credits_back != delivered)
			@(negedge clk);
		hold = 1'b1;
		repeat (OUT_CREDITS + FIFO_DEPTH)
			issue_fetch(rand_pc(), rand_line(1'b1), 1'b0, 1'b0, '0);
		repeat (10)
			@(negedge clk);
		hold = 1'b0;
		while (q_size != 0)
			@(negedge clk);
		// A few idle cycles catch any group delivered twice
		repeat (10)
			@(negedge clk);
		$display("Groups checked: %0d, errors: %0d", delivered, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_o
);

	// Free running 10 ns clock that starts low
	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Reset spans the first two rising edges and drops on a falling edge
	initial
	begin
		rst_o = 1'b1;
		repeat (2)
			@(negedge clk);
		rst_o = 1'b0;
	end

endmodule

//--- rtl/fetch_group_top.sv
`timescale 1ns/1ps

module fetch_group_top (
	input  logic                   clk,
	input  logic                   rst_i,
	// Fetch side
	input  logic                   fetch_valid_i,
	input  isa_pkg::pc_t           fetch_pc_i,
	input  fetch_pkg::line_t       fetch_line_i,
	input  logic                   hwi_i,
	input  logic                   miss_i,
	input  isa_pkg::pc_t           miss_pc_i,
	output logic                   fetch_ready_o,
	// Result side
	input  logic                   credit_i,
	output logic                   grp_valid_o,
	output fetch_pkg::group_t      grp_o,
	output fetch_pkg::slot_valid_t grp_vld_o,
	output isa_pkg::pc_t           grp_pc_o,
	output logic                   do_flow_o,
	output logic                   do_call_o,
	output logic                   do_ret_o,
	output isa_pkg::pc_t           tgt_pc_o,
	output isa_pkg::pc_t           ret_pc_o
);
	import isa_pkg::*;
	import fetch_pkg::*;

	// Producer to queue
	logic        push;
	group_t      push_grp;
	slot_valid_t push_vld;
	pc_t         push_pc;
	logic        credit_ret;

	// Queue head to consumer
	logic        head_valid;
	group_t      head_grp;
	slot_valid_t head_vld;
	pc_t         head_pc;
	logic        pop;

	group_extract u_extract (
		.clk(clk), .rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i), .hwi_i(hwi_i), .miss_i(miss_i),
		.fetch_pc_i(fetch_pc_i), .miss_pc_i(miss_pc_i), .fetch_line_i(fetch_line_i),
		.fetch_ready_o(fetch_ready_o), .credit_ret_i(credit_ret),
		.push_o(push), .push_grp_o(push_grp), .push_vld_o(push_vld), .push_pc_o(push_pc)
	);

	group_fifo u_fifo (
		.clk(clk), .rst_i(rst_i),
		.push_i(push), .push_grp_i(push_grp), .push_vld_i(push_vld), .push_pc_i(push_pc),
		.pop_i(pop), .head_valid_o(head_valid), .head_grp_o(head_grp),
		.head_vld_o(head_vld), .head_pc_o(head_pc), .credit_ret_o(credit_ret)
	);

	flow_scan u_scan (
		.clk(clk), .rst_i(rst_i),
		.head_valid_i(head_valid), .head_grp_i(head_grp), .head_vld_i(head_vld),
		.head_pc_i(head_pc), .pop_o(pop), .credit_i(credit_i),
		.grp_valid_o(grp_valid_o), .grp_o(grp_o), .grp_vld_o(grp_vld_o), .grp_pc_o(grp_pc_o),
		.tgt_pc_o(tgt_pc_o), .ret_pc_o(ret_pc_o),
		.do_flow_o(do_flow_o), .do_call_o(do_call_o), .do_ret_o(do_ret_o)
	);

endmodule

//--- rtl/flow_scan.sv
`timescale 1ns/1ps

module flow_scan (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   head_valid_i,
	input  fetch_pkg::group_t      head_grp_i,
	input  fetch_pkg::slot_valid_t head_vld_i,
	input  isa_pkg::pc_t           head_pc_i,
	output logic                   pop_o,
	input  logic                   credit_i,
	output logic                   grp_valid_o,
	output fetch_pkg::group_t      grp_o,
	output fetch_pkg::slot_valid_t grp_vld_o,
	output isa_pkg::pc_t           grp_pc_o,
	output isa_pkg::pc_t           tgt_pc_o,
	output isa_pkg::pc_t           ret_pc_o,
	output logic                   do_flow_o,
	output logic                   do_call_o,
	output logic                   do_ret_o
);
	import isa_pkg::*;
	import fetch_pkg::*;

	word_t      slot_word [SLOTS];
	pc_t        slot_pc   [SLOTS];
	opcode_t    slot_op   [SLOTS];
	link_t      slot_link [SLOTS];
	rtd_typ_t   slot_typ  [SLOTS];

	// Per-slot decode results, only set for valid slots
	logic [SLOTS-1:0] is_bl;
	logic [SLOTS-1:0] is_jsr;
	logic [SLOTS-1:0] is_ret;
	logic [SLOTS-1:0] is_call;

	logic        flow_nxt;
	logic        call_nxt;
	logic        ret_nxt;
	pc_t         tgt_nxt;
	pc_t         retpc_nxt;
	credit_cnt_t out_credit;

	// =========================================================================
	// Slot decode
	// =========================================================================

	always_comb
	begin
		for (int k = 0; k < SLOTS; k++)
		begin
			slot_word[k] = head_grp_i[k * WORD_BITS +: WORD_BITS];
			slot_pc[k]   = head_pc_i + pc_t'(k * WORD_BYTES);
			slot_op[k]   = slot_word[k][OPCODE_LSB +: $bits(opcode_t)];
			slot_link[k] = slot_word[k][LINK_LSB +: $bits(link_t)];
			slot_typ[k]  = slot_word[k][RTD_TYP_LSB +: $bits(rtd_typ_t)];

			// Link 7 on a branch is reserved and falls through as a plain op
			is_bl[k]  = head_vld_i[k] && (slot_op[k] == OP_BL) && (slot_link[k] != LINK_RSVD);
			is_jsr[k] = head_vld_i[k] && (slot_op[k] == OP_JSR);
			is_ret[k] = head_vld_i[k] && (slot_op[k] == OP_RTD) && (slot_typ[k] == '0);
			// Either form links when it names a link register
			is_call[k] = (is_bl[k] || is_jsr[k]) && (slot_link[k] != '0);
		end
	end

	// =========================================================================
	// First flow instruction in slot order
	// =========================================================================

	always_comb
	begin
		logic found;
		found     = 1'b0;
		flow_nxt  = 1'b0;
		call_nxt  = 1'b0;
		ret_nxt   = 1'b0;
		tgt_nxt   = RST_PC;
		retpc_nxt = RST_PC;
		// Lower slots come first in program order and so win
		for (int k = 0; k < SLOTS; k++)
		begin
			if (!found && (is_bl[k] || is_jsr[k]))
			begin
				found    = 1'b1;
				flow_nxt = 1'b1;
				call_nxt = is_call[k];
				// Branches are PC relative, jumps take the displacement as is
				if (is_bl[k])
					tgt_nxt = slot_pc[k] + disp_ofs(slot_word[k]);
				else
					tgt_nxt = disp_ofs(slot_word[k]);
				if (is_call[k])
					retpc_nxt = slot_pc[k] + RET_OFS;
			end
			else if (!found && is_ret[k])
			begin
				// A return stops the scan but reports no target here
				found   = 1'b1;
				ret_nxt = 1'b1;
			end
		end
	end

	// =========================================================================
	// Output credits and result register
	// =========================================================================

	// Only take the head when the outside still has room for a result
	assign pop_o = head_valid_i && (out_credit != '0);

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			out_credit  <= credit_cnt_t'(OUT_CREDITS);
			grp_valid_o <= 1'b0;
		end
		else
		begin
			grp_valid_o <= pop_o;
			case ({pop_o, credit_i})
				2'b10:   out_credit <= out_credit - 1'b1;
				2'b01:   out_credit <= out_credit + 1'b1;
				default: out_credit <= out_credit;
			endcase
		end
	end

	// Result payload, qualified by grp_valid_o
	always_ff @(posedge clk)
	begin
		if (pop_o)
		begin
			grp_o     <= head_grp_i;
			grp_vld_o <= head_vld_i;
			grp_pc_o  <= head_pc_i;
			do_flow_o <= flow_nxt;
			do_call_o <= call_nxt;
			do_ret_o  <= ret_nxt;
			tgt_pc_o  <= tgt_nxt;
			ret_pc_o  <= retpc_nxt;
		end
	end

	// The outside may not return more credit than it was given
	a_out_credit_max: assert property (@(posedge clk) disable iff (rst_i)
		out_credit <= credit_cnt_t'(OUT_CREDITS));

	// A delivered group redirects at most one way
	a_flow_xor_ret: assert property (@(posedge clk) disable iff (rst_i)
		grp_valid_o |-> !(do_ret_o && do_flow_o));

endmodule

//--- rtl/group_fifo.sv
`timescale 1ns/1ps

module group_fifo (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   push_i,
	input  fetch_pkg::group_t      push_grp_i,
	input  fetch_pkg::slot_valid_t push_vld_i,
	input  isa_pkg::pc_t           push_pc_i,
	input  logic                   pop_i,
	output logic                   head_valid_o,
	output fetch_pkg::group_t      head_grp_o,
	output fetch_pkg::slot_valid_t head_vld_o,
	output isa_pkg::pc_t           head_pc_o,
	output logic                   credit_ret_o
);
	import fetch_pkg::*;

	// Storage for the queued groups
	group_t                       grp_mem [FIFO_DEPTH];
	slot_valid_t                  vld_mem [FIFO_DEPTH];
	logic [$bits(head_pc_o)-1:0]  pc_mem  [FIFO_DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t count;

	// Step a pointer around the ring
	function automatic fifo_ptr_t next_ptr(input fifo_ptr_t p);
		next_ptr = (p == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// =========================================================================
	// Write side
	// =========================================================================

	always_ff @(posedge clk)
	begin
		if (push_i)
		begin
			grp_mem[wr_ptr] <= push_grp_i;
			vld_mem[wr_ptr] <= push_vld_i;
			pc_mem[wr_ptr]  <= push_pc_i;
		end
	end

	// =========================================================================
	// Pointers, occupancy and credit return
	// =========================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			credit_ret_o <= 1'b0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_i)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Every entry taken out frees one slot for the producer
			credit_ret_o <= pop_i;
		end
	end

	// Show-ahead head, readable in the same cycle it is popped
	assign head_valid_o = (count != '0);
	assign head_grp_o   = grp_mem[rd_ptr];
	assign head_vld_o   = vld_mem[rd_ptr];
	assign head_pc_o    = pc_mem[rd_ptr];

	// The producer's credits keep it from overrunning the queue
	a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
		push_i |-> (count < fifo_cnt_t'(FIFO_DEPTH)));

	// The consumer only pops a head it has seen as valid
	a_no_underflow: assert property (@(posedge clk) disable iff (rst_i)
		pop_i |-> (count != '0));

endmodule

//--- rtl/group_extract.sv
`timescale 1ns/1ps

module group_extract (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  fetch_valid_i,
	input  logic                  hwi_i,
	input  logic                  miss_i,
	input  isa_pkg::pc_t          fetch_pc_i,
	input  isa_pkg::pc_t          miss_pc_i,
	input  fetch_pkg::line_t      fetch_line_i,
	output logic                  fetch_ready_o,
	input  logic                  credit_ret_i,
	output logic                  push_o,
	output fetch_pkg::group_t     push_grp_o,
	output fetch_pkg::slot_valid_t push_vld_o,
	output isa_pkg::pc_t          push_pc_o
);
	import isa_pkg::*;
	import fetch_pkg::*;

	// The line is padded with NOPs so that slots past its end read as NOPs
	localparam int PAD_BITS = LINE_BITS + GROUP_BITS;

	logic [WORD_IDX_BITS-1:0] word_idx;
	logic [PAD_BITS-1:0]      padded_line;
	logic [PAD_BITS-1:0]      shifted_line;
	group_t                   aligned;
	group_t                   prev_aligned;
	pc_t                      prev_pc;
	logic                     redundant;
	logic                     accept;
	pc_t                      slot_addr [SLOTS];
	group_t                   slot_grp;
	slot_valid_t              slot_vld;
	credit_cnt_t              credit_cnt;

	// =========================================================================
	// Alignment of the cache line to the fetch PC
	// =========================================================================

	// Word index of the fetch PC inside the line
	assign word_idx = fetch_pc_i[2 +: WORD_IDX_BITS];

	assign padded_line  = {{SLOTS{NOP_WORD}}, fetch_line_i};
	assign shifted_line = padded_line >> (word_idx * WORD_BITS);
	// After the shift slot 0 is the word the PC points at
	assign aligned = shifted_line[GROUP_BITS-1:0];

	// A fetch that repeats the last accepted one must not issue twice
	assign redundant = (fetch_pc_i == prev_pc) && (aligned == prev_aligned);

	assign slot_grp = redundant ? {SLOTS{NOP_WORD}} : aligned;

	// =========================================================================
	// Slot valid bits
	// =========================================================================

	always_comb
	begin
		for (int k = 0; k < SLOTS; k++)
		begin
			slot_addr[k] = fetch_pc_i + pc_t'(k * WORD_BYTES);
			// An interrupt kills the whole group
			// A branch miss kills every slot that lies before the miss PC
			slot_vld[k] = !hwi_i && !(miss_i && (miss_pc_i > slot_addr[k]));
		end
	end

	// =========================================================================
	// Group register and push
	// =========================================================================

	assign accept = fetch_valid_i && fetch_ready_o;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			push_o       <= 1'b0;
			prev_pc      <= '0;
			prev_aligned <= '0;
		end
		else
		begin
			// The push goes out on the cycle after the fetch is taken
			push_o <= accept;
			if (accept)
			begin
				// Remember the raw aligned words, not the NOP version
				prev_pc      <= fetch_pc_i;
				prev_aligned <= aligned;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			push_grp_o <= slot_grp;
			push_vld_o <= slot_vld;
			push_pc_o  <= fetch_pc_i;
		end
	end

	// =========================================================================
	// Credits toward the group queue
	// =========================================================================

	// The credit for a push is taken on the edge that registers it, so the
	// ready flag already accounts for a push still on its way to the queue
	always_ff @(posedge clk)
	begin
		if (rst_i)
			credit_cnt <= credit_cnt_t'(FIFO_DEPTH);
		else
		begin
			case ({accept, credit_ret_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	assign fetch_ready_o = (credit_cnt != '0);

	// The queue may never hand back more credits than it has entries
	a_credit_max: assert property (@(posedge clk) disable iff (rst_i)
		credit_cnt <= credit_cnt_t'(FIFO_DEPTH));

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

	// =========================================================================
	// Fetch group geometry
	// =========================================================================

	// Width of one slot, taken from the instruction word
	localparam int WORD_BITS = $bits(isa_pkg::word_t);

	// Instructions handed on per group
	localparam int SLOTS = 4;

	// Words held in one instruction cache line
	localparam int LINE_WORDS    = 8;
	localparam int LINE_BITS     = LINE_WORDS * WORD_BITS;
	localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

	localparam int GROUP_BITS = SLOTS * WORD_BITS;

	typedef logic [LINE_BITS-1:0]  line_t;
	typedef logic [SLOTS-1:0]      slot_valid_t;
	// Slot 0 sits in the low word
	typedef logic [GROUP_BITS-1:0] group_t;

	// =========================================================================
	// Queue and flow-control sizes
	// =========================================================================

	// Entries in the group queue, also the producer's credits after reset
	localparam int FIFO_DEPTH    = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

	// Results the consumer may deliver before the outside returns credit
	localparam int OUT_CREDITS = 2;

	typedef logic [2:0]               credit_cnt_t;
	typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
	// One bit wider than a pointer so that a full queue can be told apart
	typedef logic [FIFO_PTR_BITS:0]   fifo_cnt_t;

endpackage

//--- rtl/isa_pkg.sv
package isa_pkg;

	// =========================================================================
	// Basic word and address types
	// =========================================================================

	// One instruction word as it sits in the cache line
	typedef logic [31:0] word_t;

	// Byte address of an instruction, always a multiple of four
	typedef logic [31:0] pc_t;

	// Instruction fields
	typedef logic [4:0] opcode_t;
	typedef logic [2:0] link_t;
	typedef logic [1:0] rtd_typ_t;

	// Instructions are one word long
	localparam int WORD_BYTES = 4;

	// =========================================================================
	// Field positions
	// =========================================================================

	localparam int OPCODE_LSB  = 0;
	localparam int LINK_LSB    = 5;
	localparam int RTD_TYP_LSB = 8;

	// Displacement of BL and JSR, a signed word count
	localparam int DISP_LSB  = 8;
	localparam int DISP_BITS = 24;

	// =========================================================================
	// Opcodes
	// =========================================================================

	// Relative branch, turned into a call by a non-zero link field
	localparam opcode_t OP_BL  = 5'd13;
	// Absolute jump, a call when the link field is non-zero
	localparam opcode_t OP_JSR = 5'd12;
	// Return, only type 0 redirects the fetch
	localparam opcode_t OP_RTD = 5'd16;
	localparam opcode_t OP_NOP = 5'd31;

	// Link value 7 on a BL is reserved and is never treated as flow
	localparam link_t LINK_RSVD = 3'd7;

	// Full NOP with every other field cleared
	localparam word_t NOP_WORD = {27'd0, OP_NOP};

	// A call returns to the next word
	localparam pc_t RET_OFS = 32'd4;

	// Reported as target and return PC when a group has no flow instruction
	localparam pc_t RST_PC = 32'hFFFC_0100;

	// Sign extend the displacement field and scale it from words to bytes
	function automatic pc_t disp_ofs(input word_t w);
		disp_ofs = {{($bits(pc_t) - DISP_BITS - 2){w[DISP_LSB + DISP_BITS - 1]}},
			w[DISP_LSB +: DISP_BITS], 2'b00};
	endfunction

endpackage
